// ==== edm_pkg.sv ====
package edm_pkg;

    ////////////////////////////////////////
    // machining parameter width
    ////////////////////////////////////////

    // Ton, Toff, Ip, waveform slope and the current setpoint all share this width
    typedef logic [15:0] param_t;

    ////////////////////////////////////////
    // host request synchronizer
    ////////////////////////////////////////

    // flops per request level before the matching register reloads
    localparam int SYNC_STAGES = 3;

    ////////////////////////////////////////
    // pulse timer FSM
    ////////////////////////////////////////

    typedef enum logic [1:0]
    {
        TIMER_IDLE = 2'b00,
        // gate requested, counting the latched on-time
        TIMER_ON   = 2'b01,
        // gap recovery, counting the latched off-time
        TIMER_OFF  = 2'b10
    } timer_state_t;

endpackage

// ==== edm_param_if.sv ====
`timescale 1ns/100ps

interface edm_param_if;

    // run flag, set by start and cleared by stop
    logic            is_machine;

    // held machining parameters, in clk domain
    edm_pkg::param_t ton;
    edm_pkg::param_t toff;
    edm_pkg::param_t ip;
    // ramp slope, zero gives a rectangular pulse
    edm_pkg::param_t waveform;

    modport src
    (
        output is_machine,
        output ton,
        output toff,
        output ip,
        output waveform
    );

    modport sink
    (
        input is_machine,
        input ton,
        input toff,
        input ip,
        input waveform
    );

endinterface

// ==== parameter_generator.sv ====
`timescale 1ns/100ps

module parameter_generator
(
    input  logic            clk,
    input  logic            sys_rst_n,

    input  logic            machine_start_ack,
    input  logic            machine_stop_ack,
    input  logic            change_ton_ack,
    input  logic            change_toff_ack,
    input  logic            change_ip_ack,
    input  logic            change_waveform_ack,

    input  edm_pkg::param_t ton_data_async,
    input  edm_pkg::param_t toff_data_async,
    input  edm_pkg::param_t ip_data_async,
    input  edm_pkg::param_t waveform_data_async,

    edm_param_if.src        params
);

    // bit 5 start, bit 4 stop, then ton, toff, ip, waveform
    logic [5:0]                                req_async;
    logic [5:0][edm_pkg::SYNC_STAGES-1:0]      sync_q;
    logic [5:0]                                req_q;

    logic start_req;
    logic stop_req;
    logic ton_req;
    logic toff_req;
    logic ip_req;
    logic wave_req;

    assign req_async = {machine_start_ack, machine_stop_ack, change_ton_ack,
                        change_toff_ack, change_ip_ack, change_waveform_ack};

    assign {start_req, stop_req, ton_req, toff_req, ip_req, wave_req} = req_q;

    ////////////////////////////////////////
    // request synchronizers
    ////////////////////////////////////////

    // oldest stage is retimed once more so the reload lands SYNC_STAGES+1 edges
    // after the host level is first sampled
    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            sync_q <= '0;
            req_q  <= '0;
        end
        else
        begin
            for (int i = 0; i < 6; i++)
            begin
                sync_q[i] <= {sync_q[i][edm_pkg::SYNC_STAGES-2:0], req_async[i]};
                req_q[i]  <= sync_q[i][edm_pkg::SYNC_STAGES-1];
            end
        end
    end

    ////////////////////////////////////////
    // run flag and parameter registers
    ////////////////////////////////////////

    // start wins when both levels are up
    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            params.is_machine <= 1'b0;
        else if (start_req)
            params.is_machine <= 1'b1;
        else if (stop_req)
            params.is_machine <= 1'b0;
    end

    // host keeps data stable while its change level is up and 4 cycles after
    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            params.ton      <= '0;
            params.toff     <= '0;
            params.ip       <= '0;
            params.waveform <= '0;
        end
        else
        begin
            if (ton_req)
                params.ton <= ton_data_async;
            if (toff_req)
                params.toff <= toff_data_async;
            if (ip_req)
                params.ip <= ip_data_async;
            if (wave_req)
                params.waveform <= waveform_data_async;
        end
    end

    // run flag may only rise two edges after the oldest start stage was seen
    a_start_sync: assert property (@(posedge clk) disable iff (!sys_rst_n)
        $rose(params.is_machine) |-> $past(sync_q[5][edm_pkg::SYNC_STAGES-1], 2))
        else $error("is_machine rose without a synchronized start request");

endmodule

// ==== pulse_timer.sv ====
`timescale 1ns/100ps

module pulse_timer
(
    input  logic     clk,
    input  logic     sys_rst_n,

    edm_param_if.sink params,

    output logic     pulse_on,
    output logic     pulse_first
);

    edm_pkg::timer_state_t state;
    edm_pkg::timer_state_t state_next;
    edm_pkg::param_t       cnt;
    edm_pkg::param_t       cnt_next;
    edm_pkg::param_t       toff_q;
    logic                  period_end;
    logic                  period_start;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_next   = state;
        cnt_next     = cnt;
        period_end   = 1'b0;
        period_start = 1'b0;

        case (state)
            edm_pkg::TIMER_IDLE:
                period_end = 1'b1;
            edm_pkg::TIMER_ON:
            begin
                if (cnt != '0)
                    cnt_next = cnt - edm_pkg::param_t'(1);
                else if (toff_q == '0)
                    period_end = 1'b1;
                else
                begin
                    state_next = edm_pkg::TIMER_OFF;
                    cnt_next   = toff_q - edm_pkg::param_t'(1);
                end
            end
            edm_pkg::TIMER_OFF:
            begin
                if (cnt != '0)
                    cnt_next = cnt - edm_pkg::param_t'(1);
                else
                    period_end = 1'b1;
            end
            default:
                state_next = edm_pkg::TIMER_IDLE;
        endcase

        // new period picks up the current Ton, a zero on-time parks in idle
        if (period_end)
        begin
            if (params.ton != '0)
            begin
                state_next   = edm_pkg::TIMER_ON;
                cnt_next     = params.ton - edm_pkg::param_t'(1);
                period_start = 1'b1;
            end
            else
                state_next = edm_pkg::TIMER_IDLE;
        end

        if (!params.is_machine)
        begin
            state_next   = edm_pkg::TIMER_IDLE;
            period_start = 1'b0;
        end
    end

    ////////////////////////////////////////
    // state and outputs
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            state       <= edm_pkg::TIMER_IDLE;
            cnt         <= '0;
            pulse_on    <= 1'b0;
            pulse_first <= 1'b0;
        end
        else
        begin
            state       <= state_next;
            cnt         <= cnt_next;
            pulse_on    <= (state_next == edm_pkg::TIMER_ON);
            pulse_first <= period_start;
        end
    end

    always_ff @(posedge clk)
    begin
        if (period_start)
            toff_q <= params.toff;
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!sys_rst_n)
        (state == edm_pkg::TIMER_IDLE) |-> !pulse_on)
        else $error("pulse_on high while timer idle");

    // first on cycle follows idle, off, or the last on cycle of a zero-Toff period
    a_first_entry: assert property (@(posedge clk) disable iff (!sys_rst_n)
        pulse_first |-> pulse_on
            && ($past(state) != edm_pkg::TIMER_ON || $past(cnt) == '0))
        else $error("pulse_first outside on-phase entry");

    a_stop_drops: assert property (@(posedge clk) disable iff (!sys_rst_n)
        !params.is_machine |=> !pulse_on)
        else $error("pulse_on still high after run flag fell");

endmodule

// ==== discharge_driver.sv ====
`timescale 1ns/100ps

module discharge_driver
(
    input  logic            clk,
    input  logic            sys_rst_n,

    edm_param_if.sink       params,

    input  logic            pulse_on,
    input  logic            pulse_first,

    output logic            gate,
    output edm_pkg::param_t current
);

    edm_pkg::param_t ip_q;
    edm_pkg::param_t slope_q;
    edm_pkg::param_t ip_sel;
    edm_pkg::param_t slope_sel;
    edm_pkg::param_t base_sel;
    edm_pkg::param_t cur_next;

    // one ramp step, clamped at the peak current
    function automatic edm_pkg::param_t ramp_step
    (
        input edm_pkg::param_t base,
        input edm_pkg::param_t slope,
        input edm_pkg::param_t peak
    );
        logic [$bits(edm_pkg::param_t):0] sum;
        sum = {1'b0, base} + {1'b0, slope};
        if (slope == '0)
            return peak;
        else if (sum > {1'b0, peak})
            return peak;
        else
            return edm_pkg::param_t'(sum);
    endfunction

    ////////////////////////////////////////
    // setpoint shaping
    ////////////////////////////////////////

    // first on cycle uses the live values, the latches catch up on the same edge
    always_comb
    begin
        ip_sel    = pulse_first ? params.ip : ip_q;
        slope_sel = pulse_first ? params.waveform : slope_q;
        base_sel  = pulse_first ? '0 : current;
        cur_next  = ramp_step(base_sel, slope_sel, ip_sel);
    end

    always_ff @(posedge clk)
    begin
        if (pulse_first)
        begin
            ip_q    <= params.ip;
            slope_q <= params.waveform;
        end
    end

    always_ff @(posedge clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            gate    <= 1'b0;
            current <= '0;
        end
        else
        begin
            gate    <= pulse_on;
            current <= pulse_on ? cur_next : '0;
        end
    end

    a_current_cap: assert property (@(posedge clk) disable iff (!sys_rst_n)
        gate |-> (current <= ip_q))
        else $error("current above latched Ip");

    a_gate_start: assert property (@(posedge clk) disable iff (!sys_rst_n)
        $rose(gate) |-> $past(pulse_first))
        else $error("gate rose without a pulse_first strobe");

endmodule

// ==== pulse_gen_top.sv ====
`timescale 1ns/100ps

module pulse_gen_top
(
    input  logic            clk,
    input  logic            sys_rst_n,

    input  logic            machine_start_ack,
    input  logic            machine_stop_ack,
    input  logic            change_ton_ack,
    input  logic            change_toff_ack,
    input  logic            change_ip_ack,
    input  logic            change_waveform_ack,

    input  edm_pkg::param_t ton_data_async,
    input  edm_pkg::param_t toff_data_async,
    input  edm_pkg::param_t ip_data_async,
    input  edm_pkg::param_t waveform_data_async,

    output logic            is_machine,
    output logic            gate,
    output edm_pkg::param_t current
);

    logic pulse_on;
    logic pulse_first;

    edm_param_if u_params();

    assign is_machine = u_params.is_machine;

    parameter_generator u_param_gen
    (
        .clk                 (clk),
        .sys_rst_n           (sys_rst_n),
        .machine_start_ack   (machine_start_ack),
        .machine_stop_ack    (machine_stop_ack),
        .change_ton_ack      (change_ton_ack),
        .change_toff_ack     (change_toff_ack),
        .change_ip_ack       (change_ip_ack),
        .change_waveform_ack (change_waveform_ack),
        .ton_data_async      (ton_data_async),
        .toff_data_async     (toff_data_async),
        .ip_data_async       (ip_data_async),
        .waveform_data_async (waveform_data_async),
        .params              (u_params.src)
    );

    pulse_timer u_timer
    (
        .clk         (clk),
        .sys_rst_n   (sys_rst_n),
        .params      (u_params.sink),
        .pulse_on    (pulse_on),
        .pulse_first (pulse_first)
    );

    discharge_driver u_driver
    (
        .clk         (clk),
        .sys_rst_n   (sys_rst_n),
        .params      (u_params.sink),
        .pulse_on    (pulse_on),
        .pulse_first (pulse_first),
        .gate        (gate),
        .current     (current)
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic clk,
    output logic sys_rst_n
);

    localparam int HALF_PERIOD = 10;

    initial
    begin
        clk       = 1'b0;
        sys_rst_n = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

    // reset held over three rising edges, released mid-cycle
    initial
    begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        sys_rst_n = 1'b1;
    end

endmodule

// ==== tb_pulse_gen.sv ====
`timescale 1ns/100ps

module tb_pulse_gen;

    localparam int SEED     = 82213;
    localparam int WAIT_MAX = 200;
    localparam int SEL_TON  = 0;
    localparam int SEL_TOFF = 1;
    localparam int SEL_IP   = 2;
    localparam int SEL_WAVE = 3;

    logic            clk;
    logic            sys_rst_n;
    logic            machine_start_ack;
    logic            machine_stop_ack;
    logic [3:0]      change_req;
    edm_pkg::param_t param_data [4];
    logic            is_machine;
    logic            gate;
    edm_pkg::param_t current;

    // host-programmed values indexed like change_req
    int   model [4];
    int   error_count;
    int   errors_at_start;
    int   test_count;
    int   failed_tests;
    logic gate_prev;
    int   on_index;

    tb_clock_gen u_clk_gen
    (
        .clk       (clk),
        .sys_rst_n (sys_rst_n)
    );

    pulse_gen_top u_dut
    (
        .clk                 (clk),
        .sys_rst_n           (sys_rst_n),
        .machine_start_ack   (machine_start_ack),
        .machine_stop_ack    (machine_stop_ack),
        .change_ton_ack      (change_req[SEL_TON]),
        .change_toff_ack     (change_req[SEL_TOFF]),
        .change_ip_ack       (change_req[SEL_IP]),
        .change_waveform_ack (change_req[SEL_WAVE]),
        .ton_data_async      (param_data[SEL_TON]),
        .toff_data_async     (param_data[SEL_TOFF]),
        .ip_data_async       (param_data[SEL_IP]),
        .waveform_data_async (param_data[SEL_WAVE]),
        .is_machine          (is_machine),
        .gate                (gate),
        .current             (current)
    );

    ////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////

    // setpoint in gated cycle k of a pulse where k counts from 1
    function automatic int expected_current(input int k, input int ip, input int slope);
        int level;
        level = k * slope;
        if (slope == 0 || level >= ip)
            return ip;
        return level;
    endfunction

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            error_count++;
            $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, expected,
                     actual);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: %s within %0d cycles", $time, what, WAIT_MAX);
        $display("Verification failed");
        $finish;
    endtask

    // setpoint follows the pulse shape in every gated cycle and is zero between pulses
    always @(negedge clk)
    begin
        if (sys_rst_n)
        begin
            if (gate)
                on_index = gate_prev ? on_index + 1 : 1;
            if (gate)
                check("current", expected_current(on_index, model[SEL_IP], model[SEL_WAVE]),
                      int'(current));
            else
                check("current", 0, int'(current));
        end
        gate_prev = gate;
    end

    ////////////////////////////////////////
    // host and measurement tasks
    ////////////////////////////////////////

    task automatic write_param(input int sel, input int value);
        @(negedge clk);
        param_data[sel] = edm_pkg::param_t'(value);
        change_req[sel] = 1'b1;
        repeat (4) @(negedge clk);
        change_req[sel] = 1'b0;
        repeat (4) @(negedge clk);
        model[sel] = value;
    endtask

    task automatic wait_machine(input logic level);
        int n;
        n = 0;
        while (is_machine !== level && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (is_machine !== level)
            abort_on_timeout($sformatf("is_machine did not reach %0d", level));
    endtask

    // start and stop are level requests held for 4 cycles
    task automatic request_run(input logic run);
        @(negedge clk);
        machine_start_ack = run;
        machine_stop_ack  = !run;
        repeat (4) @(negedge clk);
        machine_start_ack = 1'b0;
        machine_stop_ack  = 1'b0;
        wait_machine(run);
        // a pulse begun on the last running edge reaches gate one cycle later
        if (!run)
            @(negedge clk);
    endtask

    // counts cycles while gate holds level and thus also waits for the opposite level
    task automatic measure_run(input logic level, output int len);
        len = 0;
        while (gate === level && len < WAIT_MAX)
        begin
            len++;
            @(negedge clk);
        end
        if (len >= WAIT_MAX)
            abort_on_timeout($sformatf("gate did not leave %0d", level));
    endtask

    // entered with gate just risen
    task automatic check_period(input int ton, input int toff);
        int hi;
        int lo;
        measure_run(1'b1, hi);
        measure_run(1'b0, lo);
        check("gate high run", ton, hi);
        check("gate low run", toff, lo);
    endtask

    task automatic hold_low(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            check("gate", 0, int'(gate));
        end
    endtask

    task automatic report_test(input string name);
        test_count++;
        if (error_count == errors_at_start)
            $display("test %0d %s: ok", test_count, name);
        else
        begin
            failed_tests++;
            $display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        int skip;
        int n;
        machine_start_ack = 1'b0;
        machine_stop_ack  = 1'b0;
        change_req        = '0;
        for (int i = 0; i < 4; i++)
        begin
            param_data[i] = '0;
            model[i]      = 0;
        end
        error_count     = 0;
        errors_at_start = 0;
        test_count      = 0;
        failed_tests    = 0;
        gate_prev       = 1'b0;
        on_index        = 0;
        void'($urandom(SEED));

        n = 0;
        while (!sys_rst_n && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (!sys_rst_n)
            abort_on_timeout("reset was not released");

        @(negedge clk);
        check("is_machine", 0, int'(is_machine));
        check("gate", 0, int'(gate));
        check("current", 0, int'(current));
        hold_low(50);
        report_test("reset state");

        write_param(SEL_TON, ($urandom % 40) + 1);
        write_param(SEL_TOFF, ($urandom % 40) + 1);
        write_param(SEL_IP, ($urandom % 1000) + 1);
        write_param(SEL_WAVE, 0);
        request_run(1'b1);
        measure_run(1'b0, skip);
        repeat (3) check_period(model[SEL_TON], model[SEL_TOFF]);
        report_test("rectangular timing");

        request_run(1'b0);
        measure_run(1'b1, skip);
        write_param(SEL_WAVE, ($urandom % 200) + 1);
        request_run(1'b1);
        measure_run(1'b0, skip);
        repeat (3) check_period(model[SEL_TON], model[SEL_TOFF]);
        report_test("ramp shape");

        // the period running across the writes may mix old and new widths
        write_param(SEL_TON, ($urandom % 40) + 1);
        write_param(SEL_TOFF, ($urandom % 40) + 1);
        measure_run(1'b1, skip);
        measure_run(1'b0, skip);
        measure_run(1'b1, skip);
        measure_run(1'b0, skip);
        repeat (2) check_period(model[SEL_TON], model[SEL_TOFF]);
        report_test("parameter change");

        request_run(1'b0);
        measure_run(1'b1, skip);
        hold_low(50);
        write_param(SEL_TON, 0);
        request_run(1'b1);
        hold_low(100);
        check("is_machine", 1, int'(is_machine));
        report_test("stop and zero on-time");

        $display("tests: %0d, failed: %0d, errors: %0d", test_count, failed_tests, error_count);
        if (error_count == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== tb.f ====
edm_pkg.sv
edm_param_if.sv
parameter_generator.sv
pulse_timer.sv
discharge_driver.sv
pulse_gen_top.sv
tb_clock_gen.sv
tb_pulse_gen.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert --timescale 1ns/100ps
TOP       = tb_pulse_gen
FILELIST  = tb.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Verification failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
